/* burst_uncomp_settings.svh */
`ifndef BURST_UNCOMP_SETTINGS_SVH
`define BURST_UNCOMP_SETTINGS_SVH

// --------------------------------------------------
// packet field widths
// --------------------------------------------------

// byte address carried by command and response beats
`define BU_ADDR_W          16

// burstwrap mask, sign-extended when narrower than the address
`define BU_BURSTWRAP_W     3

// bytes still to come, counted from the current beat
`define BU_BYTE_CNT_W      8

// log2 encoded transfer size
`define BU_BURST_SIZE_W    3

// --------------------------------------------------
// response beat geometry
// --------------------------------------------------

// bytes moved by one response beat
`define BU_PKT_SYMBOLS     4

// keep in step with BU_PKT_SYMBOLS
`define BU_LG_PKT_SYMBOLS  2

`endif

/* burst_uncomp_fields_pkg.sv */
`include "burst_uncomp_settings.svh"

package burst_uncomp_fields_pkg;

   // --------------------------------------------------
   // command beat from the response fifo
   // --------------------------------------------------

   // one beat describes a whole read burst when is_compressed is set
   typedef struct packed {
      // packet delimiters
      logic                          sop;
      logic                          eop;
      // start address of the burst
      logic [`BU_ADDR_W-1:0]         addr;
      // address bits allowed to change inside the burst
      logic [`BU_BURSTWRAP_W-1:0]    burstwrap;
      // total bytes of the burst
      logic [`BU_BYTE_CNT_W-1:0]     byte_cnt;
      // log2 of bytes per transfer
      logic [`BU_BURST_SIZE_W-1:0]   burstsize;
      // set for single beat read bursts
      logic                          is_compressed;
   } cmd_beat_t;

   // --------------------------------------------------
   // response beat toward the response fabric
   // --------------------------------------------------

   // always uncompressed so no compressed flag here
   typedef struct packed {
      // sop only on the first beat of a packet
      logic                          sop;
      // eop only on the last beat of a packet
      logic                          eop;
      // address of this beat's data
      logic [`BU_ADDR_W-1:0]         addr;
      // copied from the command
      logic [`BU_BURSTWRAP_W-1:0]    burstwrap;
      // bytes left including this beat
      logic [`BU_BYTE_CNT_W-1:0]     byte_cnt;
      // copied from the command
      logic [`BU_BURST_SIZE_W-1:0]   burstsize;
   } rsp_beat_t;

endpackage

/* burst_uncomp_ctrl_pkg.sv */
`include "burst_uncomp_settings.svh"

package burst_uncomp_ctrl_pkg;

   // --------------------------------------------------
   // sequencer state
   // --------------------------------------------------

   // idle means the next valid beat is the first of a burst
   // busy covers the second and later beats of a compressed burst
   // a single beat burst never leaves idle
   typedef enum logic {
      st_idle = 1'b0,
      st_busy = 1'b1
   } seq_state_e;

   // --------------------------------------------------
   // transfer size opcode
   // --------------------------------------------------

   // bytes per transfer are 2 ** code
   // the wider codes exist for wide slaves
   typedef enum logic [`BU_BURST_SIZE_W-1:0] {
      // single byte
      size_1b   = 3'd0,
      // halfword
      size_2b   = 3'd1,
      // word
      size_4b   = 3'd2,
      size_8b   = 3'd3,
      size_16b  = 3'd4,
      size_32b  = 3'd5,
      size_64b  = 3'd6,
      // largest size the code can express
      size_128b = 3'd7
   } burst_size_e;

endpackage

/* burst_beat_sequencer.sv */
`include "burst_uncomp_settings.svh"

module burst_beat_sequencer (
   input  logic                               clk,
   input  logic                               reset,

   // command side
   input  logic                               sink_valid,
   input  burst_uncomp_fields_pkg::cmd_beat_t sink,
   output logic                               sink_ready,

   // response side
   output logic                               source_valid,
   input  logic                               source_ready,
   output burst_uncomp_fields_pkg::rsp_beat_t source,

   // address generator link
   input  logic [`BU_ADDR_W-1:0]              beat_addr,
   output logic                               first_beat,
   output logic                               beat_accept
);

   // --------------------------------------------------
   // local widths and constants
   // --------------------------------------------------

   localparam int BYTE_CNT_W = `BU_BYTE_CNT_W;
   localparam int LG_SYM     = `BU_LG_PKT_SYMBOLS;

   // counter keeps whole beats only, low byte bits are always zero
   localparam int WORD_CNT_W = BYTE_CNT_W - LG_SYM;

   // bytes per response beat at byte count width
   localparam logic [BYTE_CNT_W-1:0] NUM_SYMBOLS = BYTE_CNT_W'(`BU_PKT_SYMBOLS);

   // one response beat in counter units
   localparam logic [WORD_CNT_W-1:0] WORD_STEP =
      WORD_CNT_W'(`BU_PKT_SYMBOLS >> `BU_LG_PKT_SYMBOLS);

   burst_uncomp_ctrl_pkg::seq_state_e state_q;

   // remaining beats after the current one
   logic [WORD_CNT_W-1:0] word_cnt_q;

   // counter scaled back to bytes
   logic [BYTE_CNT_W-1:0] cnt_bytes;

   // bytes left including the beat on the bus now
   logic [BYTE_CNT_W-1:0] remaining_bytes;

   logic is_idle;
   logic last_beat;

   // --------------------------------------------------
   // beat qualification
   // --------------------------------------------------

   assign is_idle = (state_q == burst_uncomp_ctrl_pkg::st_idle);

   // a valid beat while idle starts a new burst
   assign first_beat = sink_valid & is_idle;

   // response valid follows the command directly
   assign source_valid = sink_valid;

   // beat leaves when the response side takes it
   assign beat_accept = source_valid & source_ready;

   assign cnt_bytes = {word_cnt_q, {LG_SYM{1'b0}}};

   // counter is not loaded yet on the first beat
   // so the command's own count is used there
   assign remaining_bytes = first_beat ? sink.byte_cnt : cnt_bytes;

   // uncompressed beats are always their own last beat
   // compressed bursts end when one beat of bytes is left
   assign last_beat = ~sink.is_compressed |
                      (sink_valid & (remaining_bytes == NUM_SYMBOLS));

   // --------------------------------------------------
   // idle / busy state
   // --------------------------------------------------

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state_q <= burst_uncomp_ctrl_pkg::st_idle;
      end else if (beat_accept) begin
         // last beat always returns to idle from either state
         if (last_beat) begin
            state_q <= burst_uncomp_ctrl_pkg::st_idle;
         end else begin
            state_q <= burst_uncomp_ctrl_pkg::st_busy;
         end
      end
   end

   // --------------------------------------------------
   // remaining byte counter
   // --------------------------------------------------

   // loads from the command on the first beat then counts down
   // value after the last beat is don't care
   always_ff @(posedge clk) begin
      if (beat_accept) begin
         word_cnt_q <= remaining_bytes[BYTE_CNT_W-1:LG_SYM] - WORD_STEP;
      end
   end

   // --------------------------------------------------
   // response beat assembly
   // --------------------------------------------------

   always_comb begin
      // sop only while idle so sub-bursts keep one sop per packet
      source.sop       = sink.sop & is_idle;
      // eop waits for the last beat of the burst that carries it
      source.eop       = sink.eop & last_beat;
      source.addr      = beat_addr;
      source.burstwrap = sink.burstwrap;
      source.byte_cnt  = remaining_bytes;
      source.burstsize = sink.burstsize;
   end

   // command retires from the fifo only with its last beat
   assign sink_ready = beat_accept & last_beat;

endmodule

/* burst_addr_generator.sv */
`include "burst_uncomp_settings.svh"

module burst_addr_generator (
   input  logic                               clk,

   // command beat, only addr, burstwrap and burstsize are looked at
   input  burst_uncomp_fields_pkg::cmd_beat_t sink,

   // beat status from the sequencer
   input  logic                               first_beat,
   input  logic                               beat_accept,

   // address of the response beat on the bus now
   output logic [`BU_ADDR_W-1:0]              beat_addr
);

   localparam int ADDR_W      = `BU_ADDR_W;
   localparam int BURSTWRAP_W = `BU_BURSTWRAP_W;

   // --------------------------------------------------
   // transfer size decode
   // --------------------------------------------------

   // byte step between beats for each size code
   function automatic logic [ADDR_W-1:0] size_to_step(
      input burst_uncomp_ctrl_pkg::burst_size_e size
   );
      logic [ADDR_W-1:0] step;
      case (size)
         burst_uncomp_ctrl_pkg::size_1b:   step = ADDR_W'(1);
         burst_uncomp_ctrl_pkg::size_2b:   step = ADDR_W'(2);
         burst_uncomp_ctrl_pkg::size_4b:   step = ADDR_W'(4);
         burst_uncomp_ctrl_pkg::size_8b:   step = ADDR_W'(8);
         burst_uncomp_ctrl_pkg::size_16b:  step = ADDR_W'(16);
         burst_uncomp_ctrl_pkg::size_32b:  step = ADDR_W'(32);
         burst_uncomp_ctrl_pkg::size_64b:  step = ADDR_W'(64);
         burst_uncomp_ctrl_pkg::size_128b: step = ADDR_W'(128);
         // unknown code falls back to a byte step
         default:                          step = ADDR_W'(1);
      endcase
      return step;
   endfunction

   logic [ADDR_W-1:0] addr_step;
   logic [ADDR_W-1:0] wrap_mask;

   // burst start with the wrapping bits cleared
   logic [ADDR_W-1:0] addr_base_q;

   // wrapping part of the next beat's address
   logic [ADDR_W-1:0] addr_offset_q;
   logic [ADDR_W-1:0] next_offset;

   assign addr_step =
      size_to_step(burst_uncomp_ctrl_pkg::burst_size_e'(sink.burstsize));

   // --------------------------------------------------
   // wrap mask
   // --------------------------------------------------

   // msb of burstwrap spreads over the upper address bits
   // all ones gives a plain incrementing burst
   generate
      if (ADDR_W > BURSTWRAP_W) begin : g_wrap_extend
         assign wrap_mask = {{(ADDR_W - BURSTWRAP_W){sink.burstwrap[BURSTWRAP_W-1]}},
                             sink.burstwrap};
      end else begin : g_wrap_trunc
         assign wrap_mask = sink.burstwrap[ADDR_W-1:0];
      end
   endgenerate

   // --------------------------------------------------
   // base and offset registers
   // --------------------------------------------------

   // base is fixed for the whole burst
   always_ff @(posedge clk) begin
      if (first_beat & beat_accept) begin
         addr_base_q <= sink.addr & ~wrap_mask;
      end
   end

   // first beat seeds the offset from the command address
   // carry out of the window is dropped by the mask
   assign next_offset = ((first_beat ? sink.addr : addr_offset_q) + addr_step) & wrap_mask;

   always_ff @(posedge clk) begin
      if (beat_accept) begin
         addr_offset_q <= next_offset;
      end
   end

   // --------------------------------------------------
   // beat address
   // --------------------------------------------------

   // registers are still loading on the first beat
   // so the command address goes out unchanged
   assign beat_addr = first_beat ? sink.addr : (addr_base_q | addr_offset_q);

endmodule

/* burst_uncomp_top.sv */
`include "burst_uncomp_settings.svh"

module burst_uncomp_top (
   input  logic                               clk,
   input  logic                               reset,

   // compressed or uncompressed command beats
   input  logic                               sink_valid,
   input  burst_uncomp_fields_pkg::cmd_beat_t sink,
   output logic                               sink_ready,

   // one response beat per transfer
   output logic                               source_valid,
   input  logic                               source_ready,
   output burst_uncomp_fields_pkg::rsp_beat_t source
);

   // --------------------------------------------------
   // sequencer to address generator
   // --------------------------------------------------

   logic                  first_beat;
   logic                  beat_accept;
   logic [`BU_ADDR_W-1:0] beat_addr;

   // state, byte count, delimiters and handshake
   burst_beat_sequencer u_burst_beat_sequencer (
      .clk          (clk),
      .reset        (reset),
      .sink_valid   (sink_valid),
      .sink         (sink),
      .sink_ready   (sink_ready),
      .source_valid (source_valid),
      .source_ready (source_ready),
      .source       (source),
      .beat_addr    (beat_addr),
      .first_beat   (first_beat),
      .beat_accept  (beat_accept)
   );

   // per beat address with burstwrap
   burst_addr_generator u_burst_addr_generator (
      .clk         (clk),
      .sink        (sink),
      .first_beat  (first_beat),
      .beat_accept (beat_accept),
      .beat_addr   (beat_addr)
   );

endmodule

/* burst_uncomp_tb_clock.sv */
module burst_uncomp_tb_clock #(
   parameter int PERIOD_NS    = 20,
   parameter int RESET_CYCLES = 5
) (
   output logic clk,
   output logic reset
);
   timeunit 1ns;
   timeprecision 1ps;

   // free running clock
   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // reset held for a few cycles then released on a rising edge
   initial begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
   end

endmodule

/* burst_uncomp_sva.sv */
module burst_uncomp_sva (
   input logic                               clk,
   input logic                               reset,
   input logic                               sink_valid,
   input logic                               sink_ready,
   input logic                               source_valid,
   input logic                               source_ready,
   input burst_uncomp_fields_pkg::rsp_beat_t source
);
   timeunit 1ns;
   timeprecision 1ps;

   // number of failed assertions over the run
   int fail_count = 0;

   // --------------------------------------------------
   // handshake rules
   // --------------------------------------------------

   // response valid is a plain copy of command valid
   a_valid_follows: assert property (@(posedge clk) disable iff (reset)
      source_valid == sink_valid)
      else begin
         $error("source_valid differs from sink_valid");
         fail_count++;
      end

   // command retires only with a beat that is taken
   a_ready_needs_take: assert property (@(posedge clk) disable iff (reset)
      sink_ready |-> source_ready)
      else begin
         $error("sink_ready high without source_ready");
         fail_count++;
      end

   // a taken eop beat always ends its command
   a_eop_retires: assert property (@(posedge clk) disable iff (reset)
      (source_valid && source_ready && source.eop) |-> sink_ready)
      else begin
         $error("eop beat taken without sink_ready");
         fail_count++;
      end

   // --------------------------------------------------
   // no unknowns once out of reset
   // --------------------------------------------------

   a_strobes_known: assert property (@(posedge clk) disable iff (reset)
      !$isunknown({sink_ready, source_valid}))
      else begin
         $error("handshake output is unknown");
         fail_count++;
      end

   // address registers are unloaded before the first command
   a_source_known: assert property (@(posedge clk) disable iff (reset)
      source_valid |-> !$isunknown(source))
      else begin
         $error("response beat has unknown bits");
         fail_count++;
      end

endmodule

bind burst_uncomp_top burst_uncomp_sva u_burst_uncomp_sva (
   .clk          (clk),
   .reset        (reset),
   .sink_valid   (sink_valid),
   .sink_ready   (sink_ready),
   .source_valid (source_valid),
   .source_ready (source_ready),
   .source       (source)
);

/* burst_uncomp_tb.sv */
`include "burst_uncomp_settings.svh"

module burst_uncomp_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int ADDR_W  = `BU_ADDR_W;
   localparam int BW_W    = `BU_BURSTWRAP_W;
   localparam int CNT_W   = `BU_BYTE_CNT_W;
   localparam int SYMBOLS = `BU_PKT_SYMBOLS;
   // beats of all directed tests together, sizes the watchdog
   localparam int TOTAL_BEATS = 29;
   localparam int MARGIN      = 100;

   logic                               clk;
   logic                               reset;
   logic                               sink_valid;
   burst_uncomp_fields_pkg::cmd_beat_t sink;
   logic                               sink_ready;
   logic                               source_valid;
   logic                               source_ready;
   burst_uncomp_fields_pkg::rsp_beat_t source;

   int error_count;
   int sop_count;
   int eop_count;
   // cycles where a valid beat was held back
   int stall_count;
   // every beat taken by the response side, in order
   burst_uncomp_fields_pkg::rsp_beat_t accepted_q[$];

   burst_uncomp_tb_clock u_tb_clock (.clk(clk), .reset(reset));

   burst_uncomp_top u_burst_uncomp_top (
      .clk          (clk),
      .reset        (reset),
      .sink_valid   (sink_valid),
      .sink         (sink),
      .sink_ready   (sink_ready),
      .source_valid (source_valid),
      .source_ready (source_ready),
      .source       (source)
   );

   // --------------------------------------------------
   // reference model and helpers
   // --------------------------------------------------

   function automatic burst_uncomp_fields_pkg::cmd_beat_t make_cmd(
      input bit sop, input bit eop, input logic [ADDR_W-1:0] addr,
      input logic [BW_W-1:0] bw, input int cnt,
      input burst_uncomp_ctrl_pkg::burst_size_e size, input bit compressed);
      burst_uncomp_fields_pkg::cmd_beat_t cmd;
      cmd.sop           = sop;
      cmd.eop           = eop;
      cmd.addr          = addr;
      cmd.burstwrap     = bw;
      cmd.byte_cnt      = CNT_W'(cnt);
      cmd.burstsize     = size;
      cmd.is_compressed = compressed;
      return cmd;
   endfunction

   // beat k of n, uncompressed commands are beat 0 of 1
   function automatic burst_uncomp_fields_pkg::rsp_beat_t expected_beat(
      input burst_uncomp_fields_pkg::cmd_beat_t cmd, input int k, input int n);
      burst_uncomp_fields_pkg::rsp_beat_t exp;
      logic [ADDR_W-1:0] mask;
      logic [ADDR_W-1:0] base;
      logic [ADDR_W-1:0] step;
      int i;
      // top burstwrap bit fills the upper mask bits
      for (i = 0; i < ADDR_W; i++) begin
         mask[i] = (i < BW_W) ? cmd.burstwrap[i] : cmd.burstwrap[BW_W-1];
      end
      step          = ADDR_W'(1) << cmd.burstsize;
      base          = cmd.addr & ~mask;
      exp.sop       = cmd.sop && (k == 0);
      exp.eop       = cmd.eop && (k == n - 1);
      exp.addr      = base | ((cmd.addr + ADDR_W'(k) * step) & mask);
      exp.burstwrap = cmd.burstwrap;
      exp.byte_cnt  = cmd.byte_cnt - CNT_W'(k * SYMBOLS);
      exp.burstsize = cmd.burstsize;
      return exp;
   endfunction

   task automatic compare_field(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      if (got !== exp) begin
         error_count++;
         $display("Fail %0t: %s is %0h, expected %0h", $time, name, got, exp);
      end
   endtask

   function automatic bit next_ready(input bit random_bp);
      return random_bp ? (($urandom() % 2) == 1) : 1'b1;
   endfunction

   // offers one command and checks each cycle until its last beat is taken
   task automatic send_command(input burst_uncomp_fields_pkg::cmd_beat_t cmd,
                               input bit random_bp);
      burst_uncomp_fields_pkg::rsp_beat_t exp;
      int  n_beats;
      int  k;
      bit  done;
      n_beats = cmd.is_compressed ? cmd.byte_cnt / SYMBOLS : 1;
      k       = 0;
      done    = 1'b0;
      @(posedge clk);
      sink         <= cmd;
      sink_valid   <= 1'b1;
      source_ready <= next_ready(random_bp);
      while (!done) begin
         // outputs settle by the falling edge
         @(negedge clk);
         exp = expected_beat(cmd, k, n_beats);
         // stalled beats must hold the same values
         compare_field("source_valid", source_valid, 1);
         compare_field("sop", source.sop, exp.sop);
         compare_field("eop", source.eop, exp.eop);
         compare_field("addr", source.addr, exp.addr);
         compare_field("burstwrap", source.burstwrap, exp.burstwrap);
         compare_field("byte_cnt", source.byte_cnt, exp.byte_cnt);
         compare_field("burstsize", source.burstsize, exp.burstsize);
         if (!source_ready && sink_ready) begin
            error_count++;
            $display("Fail %0t: sink_ready rose while source_ready is low", $time);
         end else begin
            compare_field("sink_ready", sink_ready, source_ready && (k == n_beats - 1));
         end
         if (source_ready) begin
            accepted_q.push_back(source);
            sop_count += source.sop;
            eop_count += source.eop;
            done = (k == n_beats - 1);
            k++;
         end else begin
            stall_count++;
         end
         @(posedge clk);
         if (!done) begin
            source_ready <= next_ready(random_bp);
         end
      end
      sink_valid   <= 1'b0;
      source_ready <= 1'b0;
   endtask

   // --------------------------------------------------
   // directed tests
   // --------------------------------------------------

   task automatic single_beat_read();
      send_command(make_cmd(1, 1, 16'h0040, 3'b111, 4, burst_uncomp_ctrl_pkg::size_4b, 1), 0);
   endtask

   // eight words, 32 bytes down to 4
   task automatic incr_burst_read();
      send_command(make_cmd(1, 1, 16'h0100, 3'b111, 32, burst_uncomp_ctrl_pkg::size_4b, 1), 0);
   endtask

   // 4 byte window from 0x1236 goes 36 37 34 35
   task automatic wrap_burst_read();
      send_command(make_cmd(1, 1, 16'h1236, 3'b011, 16, burst_uncomp_ctrl_pkg::size_1b, 1), 0);
   endtask

   task automatic passthrough_beats();
      send_command(make_cmd(1, 0, 16'h0300, 3'b111, 12, burst_uncomp_ctrl_pkg::size_4b, 0), 1);
      send_command(make_cmd(0, 0, 16'h0304, 3'b010, 8, burst_uncomp_ctrl_pkg::size_2b, 0), 1);
      send_command(make_cmd(0, 1, 16'h0308, 3'b111, 4, burst_uncomp_ctrl_pkg::size_4b, 0), 1);
   endtask

   // same burst as the free run, each taken beat meets the same model
   task automatic backpressure_burst();
      stall_count = 0;
      send_command(make_cmd(1, 1, 16'h0100, 3'b111, 32, burst_uncomp_ctrl_pkg::size_4b, 1), 1);
      if (stall_count == 0) begin
         error_count++;
         $display("back-pressure test never held a beat back, the stall path was not run");
      end
   endtask

   // one packet built from two sub-bursts
   task automatic sub_burst_packet();
      sop_count = 0;
      eop_count = 0;
      accepted_q.delete();
      send_command(make_cmd(1, 0, 16'h0200, 3'b111, 8, burst_uncomp_ctrl_pkg::size_4b, 1), 0);
      send_command(make_cmd(0, 1, 16'h0208, 3'b111, 12, burst_uncomp_ctrl_pkg::size_4b, 1), 0);
      compare_field("packet sop count", sop_count, 1);
      compare_field("packet eop count", eop_count, 1);
      compare_field("first beat sop", accepted_q[0].sop, 1);
      compare_field("last beat eop", accepted_q[accepted_q.size() - 1].eop, 1);
   endtask

   // --------------------------------------------------
   // main sequence and watchdog
   // --------------------------------------------------

   initial begin
      int sva_fails;
      error_count  = 0;
      sop_count    = 0;
      eop_count    = 0;
      stall_count  = 0;
      void'($urandom(32'h0b7c5a47));
      sink_valid   = 1'b0;
      sink         = '0;
      source_ready = 1'b0;
      @(negedge reset);
      single_beat_read();
      incr_burst_read();
      wrap_burst_read();
      passthrough_beats();
      backpressure_burst();
      sub_burst_packet();
      repeat (2) @(posedge clk);
      sva_fails = u_burst_uncomp_top.u_burst_uncomp_sva.fail_count;
      $display("tests finished with %0d check errors and %0d assertion failures",
               error_count, sva_fails);
      if (error_count == 0 && sva_fails == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

   // twenty cycles per beat is far beyond the random stall length
   initial begin
      repeat (TOTAL_BEATS * 20 + MARGIN) @(posedge clk);
      $display("timeout: the tests did not finish in time, %0d errors so far", error_count);
      $display("Done: errors found");
      $finish;
   end

endmodule

/* burst_uncomp.f */
+incdir+.
burst_uncomp_fields_pkg.sv
burst_uncomp_ctrl_pkg.sv
burst_beat_sequencer.sv
burst_addr_generator.sv
burst_uncomp_top.sv
burst_uncomp_tb_clock.sv
burst_uncomp_sva.sv
burst_uncomp_tb.sv
